//--- flist.f
common/fifo_geom_pkg.sv
common/fifo_sync_pkg.sv
common/fifo_rd_if.sv
rdfifo/gray_ptr_ctrl.sv
rdfifo/dp_ram.sv
rdfifo/rd_prefetch.sv
rtl/fifo_rdy_2ck.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal --top-module tb_top \
    -f flist.f -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

//--- test/tb_top.sv
// Testbench top that runs clocks, reset and the test sequence on the dual-clock FIFO dut_i
`timescale 1ns/1ns

module tb_top;

    localparam int ADDR_W   = 4;
    localparam int DEPTH    = 2**ADDR_W;
    localparam int PF_DEPTH = fifo_geom_pkg::PF_DEPTH;
    localparam int SETTLE   = 4 * fifo_sync_pkg::SYNC_STAGES + fifo_geom_pkg::RAM_RD_LAT
                              + PF_DEPTH + 4;  // rdclk cycles for both domains to agree
    localparam int WAIT_LIM = 4 * SETTLE + 4 * DEPTH;
    localparam int ORDER_N  = 200;
    localparam logic [31:0] SEED = 32'hd45ad6ad;

    logic              wrclk;
    logic              wrrst;
    logic              rdclk;
    logic              rdrst;
    logic              fifowr;
    logic [31:0]       fifodi;
    logic              flush;
    logic              fifoget;
    logic              fifordy;
    logic [31:0]       fifodout;
    logic              fifovld;
    logic              fifowrerr;
    logic              fiforderr;
    logic              fifofull;
    logic [ADDR_W:0]   fifolen;
    logic [ADDR_W:0]   fifolenrd;
    logic [ADDR_W-1:0] fifowa;
    logic [31:0]       wr_rng;
    logic [31:0]       rd_rng;
    int                wr_total;  // Accepted since reset or flush

    fifo_rdy_2ck #(.ADDR_W(ADDR_W), .DATA_W(32)) dut_i (.*);

    tb_checker #(.DATA_W(32)) chk_i (.*);

    initial
    begin
        rdclk = 1'b0;
        forever #50 rdclk = ~rdclk;
    end

    initial
    begin
        wrclk = 1'b0;
        forever #35 wrclk = ~wrclk;  // Unrelated to rdclk on purpose
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR in test %s: %s", chk_i.test_name, why);
        $display("=== FAIL ===");
        $finish;
    endtask

    ////////////////////
    // Write side helpers

    // fifofull is stable between wrclk edges, so it decides acceptance here
    task automatic write_word(input logic [31:0] w, output bit took);
        bit was_full;
        @(negedge wrclk);
        fifowr   = 1'b1;
        fifodi   = w;
        was_full = fifofull;
        took     = !was_full;
        if (took)
        begin
            chk_i.push_expected(w);
            wr_total++;
        end
        @(posedge wrclk);
        chk_i.check_value("fifowrerr", 32'(was_full), 32'(fifowrerr));
    endtask

    task automatic write_idle();
        @(negedge wrclk);
        fifowr = 1'b0;
    endtask

    task automatic write_burst(input int n);
        bit took;
        for (int i = 0; i < n; i++)
        begin
            wr_rng = lcg_step(wr_rng);
            write_word(wr_rng, took);
            chk_i.check_value("write accepted", 32'd1, 32'(took));
        end
        write_idle();
    endtask

    ////////////////////
    // Read side helpers

    task automatic settle();
        repeat (SETTLE) @(negedge rdclk);
    endtask

    task automatic drain_all();
        int cyc;
        cyc = 0;
        @(negedge rdclk);
        while (chk_i.pending() != 0)
        begin
            if (cyc == WAIT_LIM)
                abort_run("expected words never reached the read port");
            fifoget = 1'b1;
            cyc++;
            @(negedge rdclk);
        end
        fifoget = 1'b0;
    endtask

    task automatic wait_flush_done();
        int cyc;
        cyc = 0;
        @(negedge rdclk);
        while (fifordy !== 1'b0 || fifolen !== '0 || fifolenrd !== '0)
        begin
            if (cyc == WAIT_LIM)
                abort_run("flush did not empty the FIFO");
            cyc++;
            @(negedge rdclk);
        end
    endtask

    initial
    begin
        int n;
        int exp_len;
        int accepted;
        int rounds;
        bit took;
        bit full_stable;

        fifowr   = 1'b0;
        fifodi   = '0;
        flush    = 1'b0;
        fifoget  = 1'b0;
        wrrst    = 1'b1;
        rdrst    = 1'b1;
        wr_rng   = SEED;
        rd_rng   = ~SEED;  // Separate stream for the read process
        wr_total = 0;
        repeat (16) @(negedge rdclk);
        rdrst = 1'b0;
        @(negedge wrclk);
        wrrst = 1'b0;

        // Random gaps on both sides
        chk_i.start_test("order");
        fork
            begin : writer
                bit wr_took;
                int tries;
                for (int i = 0; i < ORDER_N; i++)
                begin
                    wr_rng = lcg_step(wr_rng);
                    repeat (int'(wr_rng[31:30])) write_idle();
                    wr_rng  = lcg_step(wr_rng);
                    wr_took = 1'b0;
                    tries   = 0;
                    while (!wr_took)
                    begin
                        if (tries == WAIT_LIM)
                            abort_run("a write stayed blocked by fifofull");
                        write_word(wr_rng, wr_took);
                        tries++;
                    end
                end
                write_idle();
            end
            begin : reader
                int taken;
                int cyc;
                taken = 0;
                cyc   = 0;
                while (taken < ORDER_N)
                begin
                    if (cyc == ORDER_N * 40)
                        abort_run("words stopped arriving at the read port");
                    @(negedge rdclk);
                    rd_rng  = lcg_step(rd_rng);
                    fifoget = (rd_rng[31:30] != 2'b00);  // About three cycles in four
                    @(posedge rdclk);
                    if (fifovld)
                        taken++;
                    cyc++;
                end
                @(negedge rdclk);
                fifoget = 1'b0;
            end
        join
        settle();
        chk_i.check_value("fifordy after drain", 0, 32'(fifordy));
        chk_i.finish_test();

        ////////////////////
        // Full and overflow

        chk_i.start_test("full");
        accepted    = 0;
        rounds      = 0;
        full_stable = 1'b0;
        while (!full_stable)
        begin
            if (rounds == 4)
                abort_run("fifofull did not stay high with reads stopped");
            took = 1'b1;
            while (took && accepted < 4 * DEPTH)
            begin
                wr_rng = lcg_step(wr_rng);
                write_word(wr_rng, took);
                if (took)
                    accepted++;
            end
            write_idle();
            settle();
            full_stable = fifofull;
            rounds++;
        end
        chk_i.check_value("words accepted", 32'(DEPTH + PF_DEPTH), 32'(accepted));
        repeat (3)
        begin
            wr_rng = lcg_step(wr_rng);
            write_word(wr_rng, took);
            chk_i.check_value("write taken while full", 0, 32'(took));
        end
        write_idle();
        drain_all();
        settle();
        chk_i.check_value("fifordy after drain", 0, 32'(fifordy));
        chk_i.finish_test();

        chk_i.start_test("underflow");
        write_burst(2);
        @(negedge rdclk);
        chk_i.check_value("fifordy before get", 0, 32'(fifordy));
        fifoget = 1'b1;
        @(posedge rdclk);
        chk_i.check_value("fiforderr", 1, 32'(fiforderr));
        chk_i.check_value("fifovld", 0, 32'(fifovld));
        drain_all();
        chk_i.finish_test();

        chk_i.start_test("lengths");
        wr_rng = lcg_step(wr_rng);
        n      = 1 + int'(wr_rng[31:28]) % (DEPTH - 1);
        write_burst(n);
        settle();
        exp_len = n - ((n < PF_DEPTH) ? n : PF_DEPTH);  // Prefetch holds the rest
        chk_i.check_value("fifolen", 32'(exp_len), 32'(fifolen));
        chk_i.check_value("fifolenrd", 32'(exp_len), 32'(fifolenrd));
        chk_i.check_value("fifowa", 32'(wr_total % DEPTH), 32'(fifowa));
        drain_all();
        chk_i.finish_test();

        ////////////////////
        // Flush

        chk_i.start_test("flush");
        write_burst(10);
        settle();
        @(negedge rdclk);
        flush = 1'b1;
        chk_i.clear_expected();
        wr_total = 0;
        @(negedge rdclk);
        flush = 1'b0;
        wait_flush_done();
        settle();
        write_burst(3);
        drain_all();
        chk_i.finish_test();

        $display("%0d tests, %0d failed, %0d errors", chk_i.tests_run, chk_i.tests_failed,
                 chk_i.total_errs);
        if (chk_i.total_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- test/tb_checker.sv
// Testbench checker, keeps the expected word order and compares every word taken at the read port
`timescale 1ns/1ns

module tb_checker #(
    parameter int DATA_W = 32
) (
    input logic              rdclk,
    input logic              rdrst,
    input logic              fifovld,
    input logic [DATA_W-1:0] fifodout
);

    logic [DATA_W-1:0] ref_q [$];  // Accepted writes, oldest first
    string             test_name;
    int                test_errs;
    int                total_errs;
    int                tests_run;
    int                tests_failed;

    // Next word the read port has to deliver
    function automatic logic [DATA_W-1:0] expected_head();
        return ref_q[0];
    endfunction

    function automatic int pending();
        return ref_q.size();
    endfunction

    task automatic push_expected(input logic [DATA_W-1:0] w);
        ref_q.push_back(w);
    endtask

    task automatic clear_expected();
        ref_q.delete();
    endtask

    ////////////////////
    // Test bookkeeping

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0)
            $display("test %-9s ok", test_name);
        else
        begin
            $display("test %-9s %0d errors", test_name, test_errs);
            tests_failed++;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s: %s expected %0h, actual %0h", test_name, what, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    ////////////////////
    // Read port watch

    always @(posedge rdclk)
    begin
        if (!rdrst && fifovld === 1'b1)
        begin
            if (ref_q.size() == 0)
            begin
                $display("ERROR in test %s: a word was taken while none was expected",
                         test_name);
                test_errs++;
                total_errs++;
            end
            else
            begin
                check_value("fifodout", 32'(expected_head()), 32'(fifodout));
                void'(ref_q.pop_front());  // Word consumed
            end
        end
    end

endmodule

//--- rtl/fifo_rdy_2ck.sv
// Dual-clock FIFO top, write strobe in wrclk and a ready/get read port in rdclk
`timescale 1ns/1ns

module fifo_rdy_2ck #(
    parameter int ADDR_W = fifo_geom_pkg::ADDR_W,
    parameter int DATA_W = fifo_geom_pkg::DATA_W
) (
    input  logic              wrclk,
    input  logic              wrrst,
    input  logic              rdclk,
    input  logic              rdrst,

    // Write side, wrclk
    input  logic              fifowr,
    input  logic [DATA_W-1:0] fifodi,

    // Read side, rdclk
    input  logic              flush,
    input  logic              fifoget,
    output logic              fifordy,
    output logic [DATA_W-1:0] fifodout,
    output logic              fifovld,

    // Status
    output logic              fifowrerr,
    output logic              fiforderr,
    output logic              fifofull,
    output logic [ADDR_W:0]   fifolen,
    output logic [ADDR_W:0]   fifolenrd,
    output logic [ADDR_W-1:0] fifowa
);

    logic we;

    fifo_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) rd_link ();

    gray_ptr_ctrl #(.ADDR_W(ADDR_W)) ctrl_i (
        .wrclk     (wrclk),
        .wrrst     (wrrst),
        .fifowr    (fifowr),
        .fifofull  (fifofull),
        .fifowrerr (fifowrerr),
        .wa        (fifowa),     // Write address doubles as status
        .we        (we),
        .fifolen   (fifolen),
        .rdclk     (rdclk),
        .rdrst     (rdrst),
        .flush     (flush),
        .fifolenrd (fifolenrd),
        .rd_link   (rd_link.ctrl)
    );

    dp_ram #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) ram_i (
        .wrclk   (wrclk),
        .we      (we),
        .wa      (fifowa),
        .wdata   (fifodi),
        .rdclk   (rdclk),
        .rd_link (rd_link.mem)
    );

    rd_prefetch #(.DATA_W(DATA_W)) pf_i (
        .rdclk     (rdclk),
        .rdrst     (rdrst),
        .rd_link   (rd_link.pf),
        .fifoget   (fifoget),
        .fifordy   (fifordy),
        .fifodout  (fifodout),
        .fifovld   (fifovld),
        .fiforderr (fiforderr)
    );

endmodule

//--- rdfifo/rd_prefetch.sv
// Read-side prefetch queue, reads ahead from the RAM and presents words on a ready/get port
`timescale 1ns/1ns

module rd_prefetch #(
    parameter int DATA_W = 32
) (
    input  logic              rdclk,
    input  logic              rdrst,
    fifo_rd_if.pf             rd_link,
    input  logic              fifoget,
    output logic              fifordy,
    output logic [DATA_W-1:0] fifodout,
    output logic              fifovld,
    output logic              fiforderr
);

    localparam int DEPTH  = fifo_geom_pkg::PF_DEPTH;
    localparam int RD_LAT = fifo_geom_pkg::RAM_RD_LAT;
    localparam int IW     = $clog2(DEPTH);      // Queue index width
    localparam int CW     = $clog2(DEPTH + 1);  // Count width, up to DEPTH

    logic [DATA_W-1:0] q_mem [DEPTH];
    logic [IW-1:0]     q_wp;
    logic [IW-1:0]     q_rp;
    logic [CW-1:0]     q_cnt;
    logic [CW-1:0]     resv;      // Held words plus reads in flight
    logic [RD_LAT-1:0] tag_pipe;  // Follows each read through the RAM
    logic              arrive;
    logic              load_out;

    ////////////////////
    // Port side

    assign fifovld   = fifoget & fifordy;
    assign fiforderr = fifoget & ~fifordy;  // Nothing to take

    assign arrive   = tag_pipe[RD_LAT-1];
    assign load_out = (q_cnt != '0) & (~fifordy | fifovld);

    // Stop asking once every slot is spoken for
    assign rd_link.fiford = rd_link.notempty & ~rd_link.flush_rd & (resv < CW'(DEPTH));

    always_ff @(posedge rdclk)
    begin
        if (rdrst || rd_link.flush_rd)
        begin
            tag_pipe <= '0;  // In-flight reads are dropped
            resv     <= '0;
        end
        else
        begin
            tag_pipe[0] <= rd_link.fiford;
            for (int i = 1; i < RD_LAT; i++)
                tag_pipe[i] <= tag_pipe[i-1];

            case ({rd_link.fiford, fifovld})
                2'b10:   resv <= resv + 1'b1;
                2'b01:   resv <= resv - 1'b1;
                default: resv <= resv;
            endcase
        end
    end

    ////////////////////
    // Circular queue

    always_ff @(posedge rdclk)
    begin
        if (rdrst || rd_link.flush_rd)
        begin
            q_wp  <= '0;
            q_rp  <= '0;
            q_cnt <= '0;
        end
        else
        begin
            if (arrive)
                q_wp <= (q_wp == IW'(DEPTH - 1)) ? '0 : q_wp + 1'b1;
            if (load_out)
                q_rp <= (q_rp == IW'(DEPTH - 1)) ? '0 : q_rp + 1'b1;

            case ({arrive, load_out})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    always_ff @(posedge rdclk)
    begin
        if (arrive)
            q_mem[q_wp] <= rd_link.rdata;
    end

    ////////////////////
    // Output word

    always_ff @(posedge rdclk)
    begin
        if (rdrst || rd_link.flush_rd)
            fifordy <= 1'b0;
        else if (load_out)
            fifordy <= 1'b1;  // Head moves up, empty or just taken
        else if (fifovld)
            fifordy <= 1'b0;
    end

    always_ff @(posedge rdclk)
    begin
        if (load_out)
            fifodout <= q_mem[q_rp];
    end

endmodule

//--- rdfifo/dp_ram.sv
// Dual-port FIFO storage, written in wrclk and read through output registers in rdclk
`timescale 1ns/1ns

module dp_ram #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
) (
    input  logic              wrclk,
    input  logic              we,
    input  logic [ADDR_W-1:0] wa,
    input  logic [DATA_W-1:0] wdata,
    input  logic              rdclk,
    fifo_rd_if.mem            rd_link
);

    localparam int RD_LAT = fifo_geom_pkg::RAM_RD_LAT;

    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic [DATA_W-1:0] rd_pipe [RD_LAT];  // Output register stages

    always_ff @(posedge wrclk)
    begin
        if (we)
            mem[wa] <= wdata;
    end

    ////////////////////
    // Read path

    always_ff @(posedge rdclk)
    begin
        if (rd_link.re)
            rd_pipe[0] <= mem[rd_link.ra];
        for (int i = 1; i < RD_LAT; i++)
            rd_pipe[i] <= rd_pipe[i-1];  // Free running, validity tracked downstream
    end

    assign rd_link.rdata = rd_pipe[RD_LAT-1];

endmodule

//--- rdfifo/gray_ptr_ctrl.sv
// Dual-clock pointer controller where gray pointers cross domains and a flush toggle clears both
`timescale 1ns/1ns

module gray_ptr_ctrl #(
    parameter int ADDR_W = 8
) (
    // Write domain
    input  logic            wrclk,
    input  logic            wrrst,
    input  logic            fifowr,
    output logic            fifofull,
    output logic            fifowrerr,
    output logic [ADDR_W-1:0] wa,
    output logic            we,
    output logic [ADDR_W:0] fifolen,

    // Read domain
    input  logic            rdclk,
    input  logic            rdrst,
    input  logic            flush,
    output logic [ADDR_W:0] fifolenrd,
    fifo_rd_if.ctrl         rd_link
);

    localparam int PW     = ADDR_W + 1;  // Pointer width with one wrap bit above the address
    localparam int SYNC_N = fifo_sync_pkg::SYNC_STAGES;

    // Read domain registers sampled by the write domain synchronizer
    logic [PW-1:0]               rd_gray;
    logic                        flush_tgl_r;

    ////////////////////
    // Write domain

    logic [PW-1:0]               wp_bin;
    logic [PW-1:0]               wp_gray;
    logic [SYNC_N-1:0][PW:0]     wr_sync;    // {flush toggle, read gray}
    logic                        flush_ack;  // Last toggle seen and echoed back
    logic                        flush_tgl_w;
    logic                        flush_wr;
    logic [PW-1:0]               rp_gray_w;
    logic [PW-1:0]               rp_bin_w;
    logic [PW-1:0]               wp_inc;

    assign flush_tgl_w = wr_sync[SYNC_N-1][PW];
    assign rp_gray_w   = wr_sync[SYNC_N-1][PW-1:0];
    assign flush_wr    = flush_tgl_w ^ flush_ack;  // One cycle per flush request
    assign rp_bin_w    = PW'(fifo_sync_pkg::gray2bin(32'(rp_gray_w), PW));
    assign wp_inc      = wp_bin + 1'b1;

    assign fifolen   = wp_bin - rp_bin_w;
    assign fifofull  = fifolen[ADDR_W];             // Exactly 2^ADDR_W words held
    assign fifowrerr = fifowr & fifofull;
    assign we        = fifowr & ~fifofull & ~flush_wr;
    assign wa        = wp_bin[ADDR_W-1:0];

    always_ff @(posedge wrclk)
    begin
        if (wrrst)
        begin
            wp_bin    <= '0;
            wp_gray   <= '0;
            wr_sync   <= '0;
            flush_ack <= 1'b0;
        end
        else
        begin
            wr_sync[0] <= {flush_tgl_r, rd_gray};
            for (int i = 1; i < SYNC_N; i++)
                wr_sync[i] <= wr_sync[i-1];

            if (flush_wr)
            begin
                wp_bin    <= '0;
                wp_gray   <= '0;
                flush_ack <= flush_tgl_w;
            end
            else if (we)
            begin
                wp_bin  <= wp_inc;
                wp_gray <= PW'(fifo_sync_pkg::bin2gray(32'(wp_inc), PW));
            end
        end
    end

    ////////////////////
    // Read domain

    logic [PW-1:0]               rp_bin;
    logic [SYNC_N-1:0][PW:0]     rd_sync;    // {flush ack, write gray}
    logic                        flush_pend;
    logic [PW-1:0]               wp_bin_r;
    logic [PW-1:0]               rp_inc;

    assign flush_pend = flush_tgl_r ^ rd_sync[SYNC_N-1][PW];  // Waiting for the echo
    assign wp_bin_r   = PW'(fifo_sync_pkg::gray2bin(32'(rd_sync[SYNC_N-1][PW-1:0]), PW));
    assign rp_inc     = rp_bin + 1'b1;

    assign fifolenrd        = wp_bin_r - rp_bin;
    assign rd_link.notempty = |fifolenrd;
    assign rd_link.flush_rd = flush | flush_pend;
    assign rd_link.ra       = rp_bin[ADDR_W-1:0];
    assign rd_link.re       = rd_link.fiford & rd_link.notempty & ~rd_link.flush_rd;

    always_ff @(posedge rdclk)
    begin
        if (rdrst)
        begin
            rp_bin      <= '0;
            rd_gray     <= '0;
            rd_sync     <= '0;
            flush_tgl_r <= 1'b0;
        end
        else
        begin
            rd_sync[0] <= {flush_ack, wp_gray};
            for (int i = 1; i < SYNC_N; i++)
                rd_sync[i] <= rd_sync[i-1];

            // Read pointer parks at zero for the whole handshake
            if (rd_link.flush_rd)
            begin
                rp_bin  <= '0;
                rd_gray <= '0;
            end
            else if (rd_link.re)
            begin
                rp_bin  <= rp_inc;
                rd_gray <= PW'(fifo_sync_pkg::bin2gray(32'(rp_inc), PW));
            end

            if (flush && !flush_pend)
                flush_tgl_r <= ~flush_tgl_r;  // New request toward wrclk
        end
    end

endmodule

//--- common/fifo_rd_if.sv
// Read-domain link between the pointer controller, the storage RAM and the prefetch queue
`timescale 1ns/1ns

interface fifo_rd_if #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
);

    logic              notempty;  // Synced occupancy above zero
    logic              fiford;    // Prefetch asks for one more word
    logic              flush_rd;  // Flush in progress, read side
    logic [ADDR_W-1:0] ra;
    logic              re;
    logic [DATA_W-1:0] rdata;

    ////////////////////
    // Views per block

    modport ctrl (input fiford, output notempty, output flush_rd, output ra, output re);

    modport mem (input re, input ra, output rdata);

    modport pf (input notempty, input flush_rd, input rdata, output fiford);

endinterface

//--- common/fifo_sync_pkg.sv
// Clock crossing constants and gray code helpers for the FIFO pointer controller
package fifo_sync_pkg;

    parameter int SYNC_STAGES = 2;   // Flops per synchronizer chain
    parameter int CONV_W      = 32;  // Widest pointer the helpers handle

    // Caller passes a zero-extended pointer, bits at or above width come back clear
    function automatic logic [CONV_W-1:0] bin2gray(input logic [CONV_W-1:0] bin,
                                                   input int width);
        logic [CONV_W-1:0] gray;
        gray = bin ^ (bin >> 1);
        for (int i = 0; i < CONV_W; i++)
            if (i >= width)
                gray[i] = 1'b0;
        return gray;
    endfunction

    function automatic logic [CONV_W-1:0] gray2bin(input logic [CONV_W-1:0] gray,
                                                   input int width);
        logic [CONV_W:0] bin;
        bin = '0;
        for (int i = CONV_W - 1; i >= 0; i--)
            if (i < width)
                bin[i] = bin[i+1] ^ gray[i];  // Running xor from the top bit down
        return bin[CONV_W-1:0];
    endfunction

endpackage

//--- common/fifo_geom_pkg.sv
// Storage geometry and prefetch constants shared by the dual-clock FIFO blocks
package fifo_geom_pkg;

    ////////////////////
    // Storage array defaults

    // Address width of the storage array, 256 words
    parameter int ADDR_W = 8;

    // Word width carried from fifodi to fifodout
    parameter int DATA_W = 32;

    ////////////////////
    // Read side pipeline

    // Words held by the prefetch queue, the presented word included
    parameter int PF_DEPTH = 5;

    // Cycles from a read strobe to data at the RAM output registers
    parameter int RAM_RD_LAT = 3;

endpackage
